/* logical_layer.f */
+incdir+common
common/logical_pkg.sv
verilog/config_regs.sv
lane/lane_striper.sv
lane/lane_scrambler.sv
lane/lane_merger.sv
verilog/logical_layer.sv
sim/logical_layer_model.sv
sim/logical_layer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the logical layer testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f logical_layer.f --top-module logical_layer_tb \
	-Mdir obj_dir -o sim_logical_layer
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_logical_layer > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if grep -qx "Simulation finished: PASS" "$log"; then
	exit 0
fi
echo "pass line not found in $log"
exit 1

/* sim/logical_layer_tb.sv */
`include "logical_defs.svh"

module logical_layer_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import logical_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_BYTES = 64;
	localparam int NUM_TESTS = 5;
	localparam int DRAIN_LIMIT = 50;
	// idle gaps can double a burst, then drain and register traffic
	localparam int TEST_CYCLES = 2 * NUM_BYTES + DRAIN_LIMIT + 40;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS * TEST_CYCLES + 100;

	logic local_clk;
	logic reset;
	byte_t transport_layer_data_in;
	logic transport_data_flag;
	byte_t transport_layer_data_out;
	logic transport_data_out_flag;
	lane_sym_t lane_0_tx_o;
	lane_sym_t lane_1_tx_o;
	lane_sym_t lane_0_rx_i;
	lane_sym_t lane_1_rx_i;
	logic c_read;
	logic c_write;
	cfg_addr_t c_address;
	cfg_word_t c_data_in;
	cfg_word_t c_data_out;

	// lane 1 delay line
	lane_sym_t skew_d1;
	lane_sym_t skew_d2;
	int skew;
	int seed = 32'hc39f69a7;
	int total_sent = 0;
	int rx_seen = 0;
	int tb_errors = 0;
	int model_errors;
	int err_mark = 0;
	int tests_run = 0;
	int tests_failed = 0;

	logical_layer dut (.*);

	logical_layer_model model (
		.clk           (local_clk),
		.reset         (reset),
		.data_in       (transport_layer_data_in),
		.data_flag     (transport_data_flag),
		.c_write       (c_write),
		.c_address     (c_address),
		.c_data_in     (c_data_in),
		.lane_0_tx     (lane_0_tx_o),
		.lane_1_tx     (lane_1_tx_o),
		.data_out      (transport_layer_data_out),
		.data_out_flag (transport_data_out_flag),
		.err_count     (model_errors)
	);

	initial begin
		local_clk = 1'b0;
		forever #(CLK_PERIOD / 2) local_clk = ~local_clk;
	end

	// loopback, lane 1 through 0 to 2 cycles of skew
	assign lane_0_rx_i = lane_0_tx_o;
	assign lane_1_rx_i = (skew == 0) ? lane_1_tx_o : (skew == 1) ? skew_d1 : skew_d2;

	always @(posedge local_clk) begin
		skew_d1 <= lane_1_tx_o;
		skew_d2 <= skew_d1;
		if (reset)
			rx_seen <= 0;
		else if (transport_data_out_flag)
			rx_seen <= rx_seen + 1;
	end

	task automatic cfg_write(input cfg_addr_t addr, input cfg_word_t data);
		@(posedge local_clk);
		c_write <= 1'b1;
		c_address <= addr;
		c_data_in <= data;
		@(posedge local_clk);
		c_write <= 1'b0;
		// resync pulse clears through the lanes
		repeat (2) @(posedge local_clk);
	endtask

	task automatic check_reg(input cfg_addr_t addr, input cfg_word_t expected, input string what);
		cfg_word_t got;
		@(posedge local_clk);
		c_read <= 1'b1;
		c_address <= addr;
		@(posedge local_clk);
		c_read <= 1'b0;
		// read data held from here on
		@(posedge local_clk);
		got = c_data_out;
		assert (got == expected)
		else begin
			$display("** Error at %0t ns: %s read 0x%0h, expected 0x%0h",
				$time, what, got, expected);
			tb_errors++;
		end
	endtask

	task automatic send_bytes(input int count);
		for (int i = 0; i < count; i++) begin
			@(posedge local_clk);
			transport_data_flag <= 1'b1;
			transport_layer_data_in <= byte_t'($random(seed));
			// now and then an idle cycle
			if ($random(seed) % 4 == 0) begin
				@(posedge local_clk);
				transport_data_flag <= 1'b0;
			end
		end
		@(posedge local_clk);
		transport_data_flag <= 1'b0;
		total_sent += count;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (rx_seen != total_sent && waited < DRAIN_LIMIT) begin
			@(posedge local_clk);
			waited++;
		end
		if (rx_seen != total_sent) begin
			$display("receive side stalled: only %0d of %0d bytes came out",
				rx_seen, total_sent);
			tb_errors++;
		end
		repeat (2) @(posedge local_clk);
	endtask

	// counters since the last clear, then clear them and read back
	task automatic close_test(input string name, input int sent);
		check_reg(`ADDR_TX_COUNT, cfg_word_t'(sent), "tx count");
		check_reg(`ADDR_RX_COUNT, cfg_word_t'(sent), "rx count");
		cfg_write(`ADDR_TX_COUNT, '0);
		cfg_write(`ADDR_RX_COUNT, '0);
		check_reg(`ADDR_TX_COUNT, '0, "tx count after clear");
		check_reg(`ADDR_RX_COUNT, '0, "rx count after clear");
		tests_run++;
		if (tb_errors + model_errors == err_mark) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name,
				tb_errors + model_errors - err_mark);
		end
		err_mark = tb_errors + model_errors;
	endtask

	task automatic run_traffic(input string name);
		send_bytes(NUM_BYTES);
		wait_drain();
		close_test(name, NUM_BYTES);
	endtask

	initial begin
		reset = 1'b1;
		transport_layer_data_in = '0;
		transport_data_flag = 1'b0;
		c_read = 1'b0;
		c_write = 1'b0;
		c_address = '0;
		c_data_in = '0;
		skew = 0;
		repeat (RESET_CYCLES) @(posedge local_clk);
		reset <= 1'b0;
		// idle lanes after reset, control reads x2 with scrambling
		repeat (4) @(posedge local_clk);
		check_reg(`ADDR_CTRL, 32'd2, "control after reset");
		close_test("reset state", 0);
		run_traffic("x2 scrambled");
		cfg_write(`ADDR_CTRL, 32'd0);
		run_traffic("x2 unscrambled");
		// lane_disable with scrambling on
		cfg_write(`ADDR_CTRL, 32'd3);
		run_traffic("x1 on lane 0");
		cfg_write(`ADDR_CTRL, 32'd2);
		skew <= 2;
		run_traffic("x2 lane 1 skew 2");
		$display("tests run %0d, failed %0d, testbench errors %0d, model errors %0d",
			tests_run, tests_failed, tb_errors, model_errors);
		if (tests_failed == 0 && tb_errors + model_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired: the tests did not finish in time, stopping the run");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* sim/logical_layer_model.sv */
`include "logical_defs.svh"

module logical_layer_model (
	input  logic                   clk,
	input  logic                   reset,
	input  logical_pkg::byte_t     data_in,
	input  logic                   data_flag,
	input  logic                   c_write,
	input  logical_pkg::cfg_addr_t c_address,
	input  logical_pkg::cfg_word_t c_data_in,
	input  logical_pkg::lane_sym_t lane_0_tx,
	input  logical_pkg::lane_sym_t lane_1_tx,
	input  logical_pkg::byte_t     data_out,
	input  logic                   data_out_flag,
	output int                     err_count
);
	timeunit 1ns;
	timeprecision 1ps;
	import logical_pkg::*;

	// one tap below each exponent of x^23+x^21+x^16+x^8+x^5+x^2+1
	localparam lfsr_t TAPS = 23'h508092;

	lfsr_t ref_lfsr [`NUM_LANES];
	int ptr;
	logic lane_disable;
	logic enable_scr;
	// expected lane tx, two stages like striper plus scrambler
	lane_sym_t [`NUM_LANES-1:0] exp_d1;
	lane_sym_t [`NUM_LANES-1:0] exp_d2;
	lane_sym_t [`NUM_LANES-1:0] lane_tx;
	// bytes sent and not yet seen at the output
	byte_t sent_q [$];
	byte_t exp_head;
	logic exp_avail;
	int errors = 0;

	assign lane_tx = {lane_1_tx, lane_0_tx};
	assign err_count = errors;

	// reference additive scrambler, lsb first, output from the top bit
	function automatic byte_t ref_scramble(input lfsr_t st_in, input byte_t d,
		output lfsr_t st_out);
		byte_t q;
		lfsr_t st;
		st = st_in;
		for (int b = 0; b < 8; b++) begin
			q[b] = d[b] ^ st[`LFSR_WIDTH-1];
			st = {st[`LFSR_WIDTH-2:0], ^(st & TAPS)};
		end
		st_out = st;
		return q;
	endfunction

	// tx side: lane choice and scrambled value per strobe
	always @(posedge clk) begin
		int lane;
		lfsr_t nxt;
		byte_t q;
		exp_d2 <= exp_d1;
		exp_d1 <= '0;
		if (reset || (c_write && c_address == `ADDR_CTRL)) begin
			// reseed, restart the deal at lane 0
			for (int k = 0; k < `NUM_LANES; k++)
				ref_lfsr[k] = `LFSR_SEED;
			ptr = 0;
			lane_disable = reset ? 1'b0 : c_data_in[0];
			enable_scr = reset ? 1'b1 : c_data_in[1];
		end else if (data_flag) begin
			lane = lane_disable ? 0 : ptr;
			q = data_in;
			if (enable_scr) begin
				q = ref_scramble(ref_lfsr[lane], data_in, nxt);
				ref_lfsr[lane] = nxt;
			end
			exp_d1[lane] <= '{valid: 1'b1, data: q};
			if (!lane_disable)
				ptr = (lane + 1) % `NUM_LANES;
		end
	end

	// rx side: output must follow send order
	always @(posedge clk) begin
		if (reset) begin
			sent_q.delete();
		end else begin
			if (data_out_flag && sent_q.size() > 0)
				void'(sent_q.pop_front());
			if (data_flag)
				sent_q.push_back(data_in);
		end
		exp_avail <= (sent_q.size() > 0);
		exp_head <= (sent_q.size() > 0) ? sent_q[0] : 8'h00;
	end

	for (genvar k = 0; k < `NUM_LANES; k++) begin : g_lane_check
		// symbol is {valid, data}
		assert property (@(posedge clk) disable iff (reset)
			lane_tx[k].valid == exp_d2[k].valid &&
			(!lane_tx[k].valid || lane_tx[k].data == exp_d2[k].data))
		else begin
			$display("** Error at %0t ns: lane %0d tx symbol %h, expected %h",
				$time, k, $sampled(lane_tx[k]), $sampled(exp_d2[k]));
			errors++;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		!data_out_flag || (exp_avail && data_out == exp_head))
	else begin
		$display("** Error at %0t ns: output byte %h, expected %h (pending %0b)",
			$time, $sampled(data_out), $sampled(exp_head), $sampled(exp_avail));
		errors++;
	end

endmodule

/* verilog/logical_layer.sv */
`include "logical_defs.svh"

module logical_layer (
	input  logic                    local_clk,
	input  logic                    reset,
	input  logical_pkg::byte_t      transport_layer_data_in,
	input  logic                    transport_data_flag,
	output logical_pkg::byte_t      transport_layer_data_out,
	output logic                    transport_data_out_flag,
	output logical_pkg::lane_sym_t  lane_0_tx_o,
	output logical_pkg::lane_sym_t  lane_1_tx_o,
	input  logical_pkg::lane_sym_t  lane_0_rx_i,
	input  logical_pkg::lane_sym_t  lane_1_rx_i,
	input  logic                    c_read,
	input  logic                    c_write,
	input  logical_pkg::cfg_addr_t  c_address,
	input  logical_pkg::cfg_word_t  c_data_in,
	output logical_pkg::cfg_word_t  c_data_out
);
	import logical_pkg::*;

	ctrl_reg_t ctrl;
	logic scr_resync;

	// striper -> scramblers
	lane_sym_t [`NUM_LANES-1:0] striped_tx;
	// scramblers -> lane pins
	lane_sym_t [`NUM_LANES-1:0] lane_tx;
	// lane pins -> scramblers
	lane_sym_t [`NUM_LANES-1:0] lane_rx;
	// descrambled rx -> merger
	lane_sym_t [`NUM_LANES-1:0] descr_rx;

	// lane pin mapping
	assign lane_0_tx_o = lane_tx[0];
	assign lane_1_tx_o = lane_tx[1];
	assign lane_rx[0] = lane_0_rx_i;
	assign lane_rx[1] = lane_1_rx_i;

	config_regs u_config_regs (
		.local_clk  (local_clk),
		.reset      (reset),
		.c_read     (c_read),
		.c_write    (c_write),
		.c_address  (c_address),
		.c_data_in  (c_data_in),
		.c_data_out (c_data_out),
		.tx_strobe  (transport_data_flag),
		.rx_strobe  (transport_data_out_flag),
		.ctrl       (ctrl),
		.scr_resync (scr_resync)
	);

	lane_striper u_striper (
		.local_clk   (local_clk),
		.reset       (reset),
		.ctrl        (ctrl),
		.scr_resync  (scr_resync),
		.byte_in     (transport_layer_data_in),
		.byte_strobe (transport_data_flag),
		.lane_tx     (striped_tx)
	);

	// one scrambler pair per lane
	for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
		lane_scrambler u_scrambler (
			.local_clk  (local_clk),
			.reset      (reset),
			.enable_scr (ctrl.enable_scr),
			.scr_resync (scr_resync),
			.tx_in      (striped_tx[g]),
			.tx_out     (lane_tx[g]),
			.rx_in      (lane_rx[g]),
			.rx_out     (descr_rx[g])
		);
	end

	lane_merger u_merger (
		.local_clk       (local_clk),
		.reset           (reset),
		.lane_disable    (ctrl.lane_disable),
		.scr_resync      (scr_resync),
		.lane_rx         (descr_rx),
		.byte_out        (transport_layer_data_out),
		.byte_out_strobe (transport_data_out_flag)
	);

endmodule

/* lane/lane_merger.sv */
`include "logical_defs.svh"

module lane_merger (
	input  logic                                    local_clk,
	input  logic                                    reset,
	input  logic                                    lane_disable,
	input  logic                                    scr_resync,
	input  logical_pkg::lane_sym_t [`NUM_LANES-1:0] lane_rx,
	output logical_pkg::byte_t                      byte_out,
	output logic                                    byte_out_strobe
);
	import logical_pkg::*;

	localparam int DEPTH = `MERGE_FIFO_DEPTH;
	localparam int AW = $clog2(DEPTH);
	localparam int PTR_W = $clog2(`NUM_LANES);
	localparam logic [PTR_W-1:0] LAST_LANE = PTR_W'(`NUM_LANES - 1);

	// lane the next byte must come from
	logic [PTR_W-1:0] exp_ptr;
	logic [PTR_W-1:0] sel;
	logic [PTR_W-1:0] sel_next;
	// head of each fifo, incoming byte when empty
	logic [`NUM_LANES-1:0] head_valid;
	byte_t [`NUM_LANES-1:0] head_data;
	logic [`NUM_LANES-1:0] pop;

	// same lane rule as the striper
	assign sel = lane_disable ? '0 : exp_ptr;
	assign sel_next = (sel == LAST_LANE) ? '0 : sel + 1'b1;

	// one pop per cycle, only from the expected lane
	always_comb begin
		pop = '0;
		if (!scr_resync && head_valid[sel])
			pop[sel] = 1'b1;
	end

	for (genvar g = 0; g < `NUM_LANES; g++) begin : g_fifo
		byte_t mem [DEPTH];
		logic [AW-1:0] rd_ptr;
		logic [AW-1:0] wr_ptr;
		logic [AW:0] count;
		logic empty;
		logic full;
		logic pop_mem;
		logic push;

		assign empty = (count == '0);
		assign full = (count == (AW+1)'(DEPTH));
		// fall-through keeps aligned lanes at one cycle
		assign head_valid[g] = !empty || lane_rx[g].valid;
		assign head_data[g] = empty ? lane_rx[g].data : mem[rd_ptr];
		assign pop_mem = pop[g] && !empty;
		// bypassed byte skips storage
		// full fifo drops unless a stored byte leaves
		assign push = lane_rx[g].valid && !(empty && pop[g]) && (!full || pop_mem);

		always_ff @(posedge local_clk) begin
			if (reset || scr_resync) begin
				rd_ptr <= '0;
				wr_ptr <= '0;
				count <= '0;
			end else begin
				if (push)
					wr_ptr <= wr_ptr + 1'b1;
				if (pop_mem)
					rd_ptr <= rd_ptr + 1'b1;
				if (push && !pop_mem)
					count <= count + 1'b1;
				else if (pop_mem && !push)
					count <= count - 1'b1;
			end
		end

		// storage
		always_ff @(posedge local_clk) begin
			if (push)
				mem[wr_ptr] <= lane_rx[g].data;
		end
	end

	// expected lane pointer
	always_ff @(posedge local_clk) begin
		if (reset || scr_resync || lane_disable)
			exp_ptr <= '0;
		else if (|pop)
			exp_ptr <= sel_next;
	end

	// registered output byte
	always_ff @(posedge local_clk) begin
		if (reset)
			byte_out_strobe <= 1'b0;
		else
			byte_out_strobe <= |pop;
		if (|pop)
			byte_out <= head_data[sel];
	end

endmodule

/* lane/lane_scrambler.sv */
`include "logical_defs.svh"

module lane_scrambler (
	input  logic                   local_clk,
	input  logic                   reset,
	input  logic                   enable_scr,
	input  logic                   scr_resync,
	input  logical_pkg::lane_sym_t tx_in,
	output logical_pkg::lane_sym_t tx_out,
	input  logical_pkg::lane_sym_t rx_in,
	output logical_pkg::lane_sym_t rx_out
);
	import logical_pkg::*;

	// direction index into the arrays below
	localparam int DIR_TX = 0;
	localparam int DIR_RX = 1;
	localparam int NUM_DIR = 2;

	// state and data after one byte
	typedef struct packed {
		lfsr_t state;
		byte_t data;
	} scr_step_t;

	lane_sym_t [NUM_DIR-1:0] dir_in;
	lane_sym_t [NUM_DIR-1:0] dir_out;
	// separate tx and rx generators
	lfsr_t [NUM_DIR-1:0] lfsr;
	scr_step_t [NUM_DIR-1:0] step;

	// additive scrambling is its own inverse
	// so the same step serves tx and rx
	function automatic scr_step_t scr_byte(input lfsr_t state, input byte_t din);
		scr_step_t res;
		lfsr_t s;
		logic fb;
		s = state;
		// lsb first, one shift per bit
		for (int b = 0; b < 8; b++) begin
			res.data[b] = din[b] ^ s[`LFSR_WIDTH-1];
			// taps for x^23+x^21+x^16+x^8+x^5+x^2+1
			fb = s[22] ^ s[20] ^ s[15] ^ s[7] ^ s[4] ^ s[1];
			s = {s[`LFSR_WIDTH-2:0], fb};
		end
		res.state = s;
		return res;
	endfunction

	assign dir_in[DIR_TX] = tx_in;
	assign dir_in[DIR_RX] = rx_in;
	assign tx_out = dir_out[DIR_TX];
	assign rx_out = dir_out[DIR_RX];

	// next byte for each direction
	always_comb begin
		for (int d = 0; d < NUM_DIR; d++)
			step[d] = scr_byte(lfsr[d], dir_in[d].data);
	end

	always_ff @(posedge local_clk) begin
		for (int d = 0; d < NUM_DIR; d++) begin
			// both ends reseed together on a control write
			if (reset || scr_resync)
				lfsr[d] <= `LFSR_SEED;
			else if (enable_scr && dir_in[d].valid)
				lfsr[d] <= step[d].state;
			// valid passes through with one cycle delay
			if (reset)
				dir_out[d].valid <= 1'b0;
			else
				dir_out[d].valid <= dir_in[d].valid;
			// bypass when scrambling is off, lfsr holds
			if (dir_in[d].valid)
				dir_out[d].data <= enable_scr ? step[d].data : dir_in[d].data;
		end
	end

endmodule

/* lane/lane_striper.sv */
`include "logical_defs.svh"

module lane_striper (
	input  logic                                    local_clk,
	input  logic                                    reset,
	input  logical_pkg::ctrl_reg_t                  ctrl,
	input  logic                                    scr_resync,
	input  logical_pkg::byte_t                      byte_in,
	input  logic                                    byte_strobe,
	output logical_pkg::lane_sym_t [`NUM_LANES-1:0] lane_tx
);
	import logical_pkg::*;

	localparam int PTR_W = $clog2(`NUM_LANES);
	localparam logic [PTR_W-1:0] LAST_LANE = PTR_W'(`NUM_LANES - 1);

	// lane for the next strobe
	logic [PTR_W-1:0] ptr;
	// lane used this cycle
	logic [PTR_W-1:0] sel;
	logic [PTR_W-1:0] sel_next;

	// x1 mode pins everything to lane 0
	// resync restarts the deal at lane 0 straight away
	assign sel = (ctrl.lane_disable || scr_resync) ? '0 : ptr;

	// round-robin wrap
	assign sel_next = (sel == LAST_LANE) ? '0 : sel + 1'b1;

	// lane pointer
	always_ff @(posedge local_clk) begin
		if (reset) begin
			ptr <= '0;
		end else if (ctrl.lane_disable) begin
			ptr <= '0;
		end else if (byte_strobe) begin
			ptr <= sel_next;
		end else begin
			// idle cycle still picks up a resync
			ptr <= sel;
		end
	end

	// one lane valid per strobe at most
	always_ff @(posedge local_clk) begin
		for (int i = 0; i < `NUM_LANES; i++) begin
			if (reset)
				lane_tx[i].valid <= 1'b0;
			else
				lane_tx[i].valid <= byte_strobe && (sel == PTR_W'(i));
			// data only loads on the chosen lane
			if (byte_strobe && (sel == PTR_W'(i)))
				lane_tx[i].data <= byte_in;
		end
	end

endmodule

/* verilog/config_regs.sv */
`include "logical_defs.svh"

module config_regs (
	input  logic                    local_clk,
	input  logic                    reset,
	input  logic                    c_read,
	input  logic                    c_write,
	input  logical_pkg::cfg_addr_t  c_address,
	input  logical_pkg::cfg_word_t  c_data_in,
	output logical_pkg::cfg_word_t  c_data_out,
	input  logic                    tx_strobe,
	input  logic                    rx_strobe,
	output logical_pkg::ctrl_reg_t  ctrl,
	output logic                    scr_resync
);
	import logical_pkg::*;

	// x2 mode, scrambling on
	localparam ctrl_reg_t CTRL_RESET = '{enable_scr: 1'b1, lane_disable: 1'b0};
	// zero fill above the control bits on readback
	localparam int CTRL_PAD = $bits(cfg_word_t) - $bits(ctrl_reg_t);

	count_t tx_count;
	count_t rx_count;
	logic wr_ctrl;
	logic wr_tx_count;
	logic wr_rx_count;

	// write decode
	assign wr_ctrl = c_write && (c_address == `ADDR_CTRL);
	assign wr_tx_count = c_write && (c_address == `ADDR_TX_COUNT);
	assign wr_rx_count = c_write && (c_address == `ADDR_RX_COUNT);

	// control register and the resync pulse
	always_ff @(posedge local_clk) begin
		if (reset) begin
			ctrl <= CTRL_RESET;
			scr_resync <= 1'b0;
		end else begin
			// one cycle pulse per control write
			scr_resync <= wr_ctrl;
			if (wr_ctrl)
				ctrl <= ctrl_reg_t'(c_data_in[$bits(ctrl_reg_t)-1:0]);
		end
	end

	// byte counters, any write clears
	always_ff @(posedge local_clk) begin
		if (reset) begin
			tx_count <= '0;
			rx_count <= '0;
		end else begin
			if (wr_tx_count)
				tx_count <= '0;
			else if (tx_strobe)
				tx_count <= tx_count + 1'b1;
			if (wr_rx_count)
				rx_count <= '0;
			else if (rx_strobe)
				rx_count <= rx_count + 1'b1;
		end
	end

	// registered read port, holds until next read
	always_ff @(posedge local_clk) begin
		if (reset) begin
			c_data_out <= '0;
		end else if (c_read) begin
			case (c_address)
				`ADDR_CTRL:     c_data_out <= {{CTRL_PAD{1'b0}}, ctrl};
				`ADDR_TX_COUNT: c_data_out <= tx_count;
				`ADDR_RX_COUNT: c_data_out <= rx_count;
				// unmapped
				default:        c_data_out <= '0;
			endcase
		end
	end

endmodule

/* common/logical_pkg.sv */
`include "logical_defs.svh"

package logical_pkg;

	// one transport or lane data byte
	typedef logic [7:0] byte_t;

	// symbol on every lane port
	typedef struct packed {
		logic valid;
		byte_t data;
	} lane_sym_t;

	// scrambler state
	typedef logic [`LFSR_WIDTH-1:0] lfsr_t;

	// config space address and data
	typedef logic [3:0] cfg_addr_t;
	typedef logic [31:0] cfg_word_t;

	// tx and rx byte counters
	typedef logic [31:0] count_t;

	// control register
	// enable_scr sits at bit 1, lane_disable at bit 0
	// so the reset value reads back as 2
	typedef struct packed {
		logic enable_scr;
		logic lane_disable;
	} ctrl_reg_t;

endpackage

/* common/logical_defs.svh */
`ifndef LOGICAL_DEFS_SVH
`define LOGICAL_DEFS_SVH

// lanes in the link, x2 when both are enabled
`define NUM_LANES 2

// additive scrambler, x^23+x^21+x^16+x^8+x^5+x^2+1
`define LFSR_WIDTH 23

// seed after reset or any control write
`define LFSR_SEED {`LFSR_WIDTH{1'b1}}

// per-lane rx buffer, bounds the tolerated lane skew
`define MERGE_FIFO_DEPTH 4

// config space map
`define ADDR_CTRL 4'd0
`define ADDR_TX_COUNT 4'd1
`define ADDR_RX_COUNT 4'd2

`endif
